// ==== Makefile ====
TOP = tb_gauntlet_io

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== control_mapper.sv ====
// ##############################
// Keyboard event capture, Gauntlet and tank key tables
// Joystick merge into active-low player and system inputs
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "gauntlet_defs.svh"

module control_mapper (
	input  wire                   clk_sys,
	input  wire                   rst,
	input  wire gauntlet_pkg::key_t    ps2_key,
	input  wire gauntlet_pkg::joy_t    joy0,
	input  wire gauntlet_pkg::joy_t    joy1,
	input  wire gauntlet_pkg::joy_t    joy2,
	input  wire gauntlet_pkg::joy_t    joy3,
	input  wire                   service,
	input  wire gauntlet_pkg::byte_t   slap_type,
	output gauntlet_pkg::player_t p1,
	output gauntlet_pkg::player_t p2,
	output gauntlet_pkg::player_t p3,
	output gauntlet_pkg::player_t p4,
	output logic [4:0]            sys_n
);

	import gauntlet_pkg::*;

	localparam int coin_base = 32; // Coins follow the four player bytes

	logic [35:0] held;      // Held keys, players 1..4 then coins 1..4
	logic        key_tgl_q;
	logic        key_event;
	logic        key_hit;
	logic [5:0]  key_idx;
	logic [8:0]  key_code;  // Extended flag and scan code

	// Bit position of a player input inside held
	function automatic logic [5:0] held_idx(input int unsigned pl, input int unsigned b);
		return 6'(pl * 8 + b);
	endfunction

	// Key OR joystick, then inverted
	function automatic player_t player_map(input player_t k, input joy_t j);
		return {~(k[7:4] | j[3:0]), ~k[3:2], ~(k[1] | j[4]), ~(k[0] | j[5])};
	endfunction

	assign key_code  = ps2_key[8:0];
	assign key_event = (key_tgl_q != ps2_key[10]); // New event on any toggle

	// ##############################
	// Scan code lookup
	// ##############################
	always_comb begin
		key_hit = 1'b1;
		key_idx = '0;
		if (slap_type == `SLAP_TANK) begin
			case (key_code)
				9'h023: key_idx = held_idx(0, 7); // R back
				9'h01B: key_idx = held_idx(0, 6); // L back
				9'h024: key_idx = held_idx(0, 5); // R forward
				9'h01D: key_idx = held_idx(0, 4); // L forward
				9'h02D: key_idx = held_idx(0, 3); // R thumb
				9'h015: key_idx = held_idx(0, 2); // L thumb
				9'h02B: key_idx = held_idx(0, 1); // R trigger
				9'h01C: key_idx = held_idx(0, 0); // L trigger
				{1'b0, `KEY_START1}: key_idx = held_idx(2, 0);
				{1'b0, `KEY_START2}: key_idx = held_idx(2, 1);
				{1'b0, `KEY_COIN1}:  key_idx = 6'(coin_base);
				{1'b0, `KEY_COIN2}:  key_idx = 6'(coin_base + 1);
				default: key_hit = 1'b0;
			endcase
		end else begin
			// Arrows match with or without the extended flag
			casez (key_code)
				{1'b?, `KEY_UP}:    key_idx = held_idx(0, 7);
				{1'b?, `KEY_DOWN}:  key_idx = held_idx(0, 6);
				{1'b?, `KEY_LEFT}:  key_idx = held_idx(0, 5);
				{1'b?, `KEY_RIGHT}: key_idx = held_idx(0, 4);
				9'h014: key_idx = held_idx(0, 1); // Fire, ctrl
				9'h011: key_idx = held_idx(0, 0); // Magic, alt
				9'h02D: key_idx = held_idx(1, 7); // Up, R
				9'h02B: key_idx = held_idx(1, 6); // Down, F
				9'h023: key_idx = held_idx(1, 5); // Left, D
				9'h034: key_idx = held_idx(1, 4); // Right, G
				9'h01C: key_idx = held_idx(1, 1); // Fire, A
				9'h01B: key_idx = held_idx(1, 0); // Magic, S
				{1'b0, `KEY_COIN1}: key_idx = 6'(coin_base);
				{1'b0, `KEY_COIN2}: key_idx = 6'(coin_base + 1);
				{1'b0, `KEY_COIN3}: key_idx = 6'(coin_base + 2);
				{1'b0, `KEY_COIN4}: key_idx = 6'(coin_base + 3);
				default: key_hit = 1'b0;
			endcase
		end
	end

	// ##############################
	// Held key state
	// ##############################
	always_ff @(posedge clk_sys) begin
		key_tgl_q <= ps2_key[10]; // Tracks the toggle through reset too
		if (rst)
			held <= '0;
		else if (key_event && key_hit)
			held[key_idx] <= ps2_key[9];
	end

	// Joystick bits pass straight through
	assign p1 = player_map(held[7:0], joy0);
	assign p2 = player_map(held[15:8], joy1);
	assign p3 = player_map(held[23:16], joy2);
	assign p4 = player_map(held[31:24], joy3);

	assign sys_n = {~service,
		~(held[coin_base]     | joy0[6]),
		~(held[coin_base + 1] | joy1[6]),
		~(held[coin_base + 2] | joy2[6]),
		~(held[coin_base + 3] | joy3[6])};

endmodule

`default_nettype wire

// ==== dual_port_rom.sv ====
// ##############################
// Dual-port RAM, write port plus registered read port
// ##############################
`timescale 1ns/1ps
`default_nettype none

module dual_port_rom #(
	parameter type payload_t = logic [7:0],
	parameter int  aw        = 14
) (
	input  wire            clk_sys,
	input  wire            we,
	input  wire [aw-1:0]   waddr,
	input  wire payload_t  wdata,
	input  wire [aw-1:0]   raddr,
	output payload_t       rdata
);

	payload_t mem [2**aw]; // Filled by the download

	// Write port
	always_ff @(posedge clk_sys) begin
		if (we) mem[waddr] <= wdata;
	end

	// Read port, old data on a same-cycle collision
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== gauntlet_defs.svh ====
// ##############################
// Download indices, ROM region bases and widths, slapstic types, key codes
// ##############################
`ifndef GAUNTLET_DEFS_SVH
`define GAUNTLET_DEFS_SVH

// Download stream indices
`define DL_INDEX_ROM   8'd0
`define DL_INDEX_SLAP  8'd1
`define DL_INDEX_DIP   8'd254

`define SLAP_DEFAULT   8'd104   // Gauntlet
`define SLAP_TANK      8'd118   // Tank-control layout

// Byte addresses in the ROM download
`define PROG_A_BASE    25'h0C0000
`define PROG_B_BASE    25'h100000
`define SND_HI_BASE    25'h140000
`define SND_LO_BASE    25'h148000
`define CHR_BASE       25'h14C000

`define PROG_AW        15   // Word address, per program bank
`define SND_HI_AW      15
`define SND_LO_AW      14
`define CHR_AW         14

// Scan codes shared by both layouts
`define KEY_UP         8'h75
`define KEY_DOWN       8'h72
`define KEY_LEFT       8'h6B
`define KEY_RIGHT      8'h74
`define KEY_COIN1      8'h2E
`define KEY_COIN2      8'h36
`define KEY_COIN3      8'h3D
`define KEY_COIN4      8'h3E
`define KEY_START1     8'h16
`define KEY_START2     8'h1E

`endif

// ==== gauntlet_io.sv ====
// ##############################
// Top level, loader, ROM bank and control mapper
// ##############################
`timescale 1ns/1ps
`default_nettype none

module gauntlet_io (
	input  wire                      clk_sys,
	input  wire                      rst,
	input  wire                      dl_wr,
	input  wire                      dl_active,
	input  wire gauntlet_pkg::byte_t      dl_index,
	input  wire gauntlet_pkg::dl_addr_t   dl_addr,
	input  wire gauntlet_pkg::byte_t      dl_data,
	input  wire gauntlet_pkg::prog_addr_t prog_addr,
	input  wire gauntlet_pkg::snd_addr_t  snd_addr,
	input  wire gauntlet_pkg::chr_addr_t  chr_addr,
	input  wire gauntlet_pkg::key_t       ps2_key,
	input  wire gauntlet_pkg::joy_t       joy0,
	input  wire gauntlet_pkg::joy_t       joy1,
	input  wire gauntlet_pkg::joy_t       joy2,
	input  wire gauntlet_pkg::joy_t       joy3,
	input  wire                      service,
	output gauntlet_pkg::word_t      prog_data,
	output gauntlet_pkg::byte_t      snd_data,
	output gauntlet_pkg::byte_t      chr_data,
	output logic [63:0]              dip_sw,
	output gauntlet_pkg::byte_t      slap_type,
	output logic                     game_rst,
	output gauntlet_pkg::player_t    p1,
	output gauntlet_pkg::player_t    p2,
	output gauntlet_pkg::player_t    p3,
	output gauntlet_pkg::player_t    p4,
	output logic [4:0]               sys_n
);

	import gauntlet_pkg::*;

	logic     prog_a_we, prog_b_we, snd_hi_we, snd_lo_we, chr_we; // One strobe per region
	word_t    wr_word;
	byte_t    wr_byte;
	dl_addr_t wr_addr;

	rom_loader u_rom_loader (.*);

	rom_bank u_rom_bank (.*);

	control_mapper u_control_mapper (.*);

endmodule

`default_nettype wire

// ==== gauntlet_pkg.sv ====
// ##############################
// Shared data and address types of the Gauntlet support logic
// ##############################
`default_nettype none

package gauntlet_pkg;

	// Download stream and 8-bit ROM payload
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;   // Program ROM word

	// ##############################
	// Addresses
	// ##############################
	typedef logic [24:0] dl_addr_t;   // Download byte address
	typedef logic [18:0] prog_addr_t; // Core program word address
	typedef logic [15:0] snd_addr_t;
	typedef logic [13:0] chr_addr_t;

	// ##############################
	// Controls
	// ##############################
	typedef logic [7:0]  player_t;    // Active low
	typedef logic [15:0] joy_t;

	// [10] toggle per event, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] key_t;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+.
gauntlet_pkg.sv
dual_port_rom.sv
rom_loader.sv
rom_bank.sv
control_mapper.sv
gauntlet_io.sv
tb_gauntlet_io.sv

// ==== rom_bank.sv ====
// ##############################
// Program, audio and character ROMs with read muxes
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "gauntlet_defs.svh"

module rom_bank (
	input  wire                      clk_sys,
	input  wire                      prog_a_we,
	input  wire                      prog_b_we,
	input  wire                      snd_hi_we,
	input  wire                      snd_lo_we,
	input  wire                      chr_we,
	input  wire gauntlet_pkg::word_t      wr_word,
	input  wire gauntlet_pkg::byte_t      wr_byte,
	input  wire gauntlet_pkg::dl_addr_t   wr_addr,
	input  wire gauntlet_pkg::prog_addr_t prog_addr,
	input  wire gauntlet_pkg::snd_addr_t  snd_addr,
	input  wire gauntlet_pkg::chr_addr_t  chr_addr,
	output gauntlet_pkg::word_t      prog_data,
	output gauntlet_pkg::byte_t      snd_data,
	output gauntlet_pkg::byte_t      chr_data
);

	import gauntlet_pkg::*;

	// Core-side pages of the two program banks
	localparam logic [3:0] prog_a_page = 4'd0;
	localparam logic [3:0] prog_b_page = 4'd4;

	word_t prog_a_q, prog_b_q;
	byte_t snd_hi_q, snd_lo_q;
	logic  sel_a_q, sel_b_q; // Aligned with the read data
	logic  sel_hi_q;

	// ##############################
	// Storage
	// ##############################
	dual_port_rom #(.payload_t(word_t), .aw(`PROG_AW)) u_prog_a (
		.clk_sys(clk_sys), .we(prog_a_we), .waddr(wr_addr[`PROG_AW:1]), .wdata(wr_word),
		.raddr(prog_addr[`PROG_AW-1:0]), .rdata(prog_a_q)
	);

	dual_port_rom #(.payload_t(word_t), .aw(`PROG_AW)) u_prog_b (
		.clk_sys(clk_sys), .we(prog_b_we), .waddr(wr_addr[`PROG_AW:1]), .wdata(wr_word),
		.raddr(prog_addr[`PROG_AW-1:0]), .rdata(prog_b_q)
	);

	dual_port_rom #(.payload_t(byte_t), .aw(`SND_HI_AW)) u_snd_hi ( // 0x140000 region
		.clk_sys(clk_sys), .we(snd_hi_we), .waddr(wr_addr[`SND_HI_AW-1:0]), .wdata(wr_byte),
		.raddr(snd_addr[`SND_HI_AW-1:0]), .rdata(snd_hi_q)
	);

	dual_port_rom #(.payload_t(byte_t), .aw(`SND_LO_AW)) u_snd_lo ( // 0x148000 region
		.clk_sys(clk_sys), .we(snd_lo_we), .waddr(wr_addr[`SND_LO_AW-1:0]), .wdata(wr_byte),
		.raddr(snd_addr[`SND_LO_AW-1:0]), .rdata(snd_lo_q)
	);

	dual_port_rom #(.payload_t(byte_t), .aw(`CHR_AW)) u_chr (
		.clk_sys(clk_sys), .we(chr_we), .waddr(wr_addr[`CHR_AW-1:0]), .wdata(wr_byte),
		.raddr(chr_addr), .rdata(chr_data)
	);

	// ##############################
	// Read select, one stage
	// ##############################
	always_ff @(posedge clk_sys) begin
		sel_a_q  <= (prog_addr[18:15] == prog_a_page);
		sel_b_q  <= (prog_addr[18:15] == prog_b_page);
		sel_hi_q <= snd_addr[15];
	end

	// Unmapped program pages read as zero
	assign prog_data = sel_a_q ? prog_a_q :
		sel_b_q ? prog_b_q : '0;
	assign snd_data  = sel_hi_q ? snd_hi_q : snd_lo_q;

endmodule

`default_nettype wire

// ==== rom_loader.sv ====
// ##############################
// Download decoder, byte pairing, region write strobes
// Slapstic and DIP registers, game reset
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "gauntlet_defs.svh"

module rom_loader (
	input  wire                    clk_sys,
	input  wire                    rst,
	input  wire                    dl_wr,
	input  wire                    dl_active,
	input  wire gauntlet_pkg::byte_t    dl_index,
	input  wire gauntlet_pkg::dl_addr_t dl_addr,
	input  wire gauntlet_pkg::byte_t    dl_data,
	output logic                   prog_a_we,
	output logic                   prog_b_we,
	output logic                   snd_hi_we,
	output logic                   snd_lo_we,
	output logic                   chr_we,
	output gauntlet_pkg::word_t    wr_word,
	output gauntlet_pkg::byte_t    wr_byte,
	output gauntlet_pkg::dl_addr_t wr_addr,
	output gauntlet_pkg::byte_t    slap_type,
	output logic [63:0]            dip_sw,
	output logic                   game_rst
);

	import gauntlet_pkg::*;

	// Region bases as vectors, for slicing
	localparam dl_addr_t prog_a_base = `PROG_A_BASE;
	localparam dl_addr_t prog_b_base = `PROG_B_BASE;
	localparam dl_addr_t snd_hi_base = `SND_HI_BASE;
	localparam dl_addr_t snd_lo_base = `SND_LO_BASE;
	localparam dl_addr_t chr_base    = `CHR_BASE;

	byte_t prev_byte; // Even byte waiting for its odd partner
	logic  rom_wr;
	logic  odd_addr;

	assign rom_wr   = dl_wr && dl_active && (dl_index == `DL_INDEX_ROM);
	assign odd_addr = dl_addr[0];

	// ##############################
	// Region decode
	// ##############################
	// Program banks take a word on the odd byte only
	assign prog_a_we = rom_wr && odd_addr &&
		(dl_addr[24:`PROG_AW+1] == prog_a_base[24:`PROG_AW+1]);
	assign prog_b_we = rom_wr && odd_addr &&
		(dl_addr[24:`PROG_AW+1] == prog_b_base[24:`PROG_AW+1]);
	assign snd_hi_we = rom_wr && (dl_addr[24:`SND_HI_AW] == snd_hi_base[24:`SND_HI_AW]);
	assign snd_lo_we = rom_wr && (dl_addr[24:`SND_LO_AW] == snd_lo_base[24:`SND_LO_AW]);
	assign chr_we    = rom_wr && (dl_addr[24:`CHR_AW] == chr_base[24:`CHR_AW]);

	// Even byte high, current byte low
	assign wr_word = {prev_byte, dl_data};
	assign wr_byte = dl_data;
	assign wr_addr = dl_addr;

	always_ff @(posedge clk_sys) begin
		if (rom_wr) prev_byte <= dl_data;
	end

	// ##############################
	// Configuration registers
	// ##############################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			slap_type <= `SLAP_DEFAULT;
			dip_sw    <= '0;
		end else if (dl_wr) begin
			if (dl_index == `DL_INDEX_SLAP) slap_type <= dl_data; // Any address
			// Eight switch bytes, byte k at bits 8k+7..8k
			if ((dl_index == `DL_INDEX_DIP) && (dl_addr[24:3] == '0))
				dip_sw[{dl_addr[2:0], 3'b000} +: 8] <= dl_data;
		end
	end

	// Core held in reset for the whole download
	assign game_rst = rst | dl_active;

endmodule

`default_nettype wire

// ==== tb_gauntlet_io.sv ====
// ##############################
// Directed testbench for gauntlet_io, ROM download, config and key mapping
// ##############################
`timescale 1ns/1ps
`default_nettype none
`include "gauntlet_defs.svh"

module tb_gauntlet_io;

	import gauntlet_pkg::*;

	localparam int n_prog_bytes = 64;  // Per program bank
	localparam int n_byte_bytes = 32;  // Per audio or character region
	localparam int n_dl_bytes   = 2 * n_prog_bytes + 3 * n_byte_bytes + 12;
	localparam int n_reads      = n_prog_bytes + 2 * n_byte_bytes + 8;
	localparam int n_key_evts   = 30;
	// Cycles of 4 ns, twice over for margin
	localparam int limit_ns     = (n_dl_bytes + n_reads + 3 * n_key_evts + 40) * 4 * 2;

	logic clk_sys = 1'b0;
	logic rst, dl_wr, dl_active, service, game_rst;
	byte_t dl_index, dl_data, snd_data, chr_data, slap_type;
	dl_addr_t dl_addr;
	prog_addr_t prog_addr;
	snd_addr_t snd_addr;
	chr_addr_t chr_addr;
	key_t ps2_key;
	joy_t joy0, joy1, joy2, joy3;
	word_t prog_data;
	logic [63:0] dip_sw;
	player_t p1, p2, p3, p4;
	logic [4:0] sys_n;

	byte_t rom_img [int];          // Reference image by download address
	prog_addr_t prog_q [$];        // Pending program reads
	int err_cnt = 0;
	int test_cnt = 0;
	int fail_cnt = 0;

	gauntlet_io u_dut (.*);

	always #2 clk_sys = ~clk_sys;

	initial begin
		#(limit_ns);
		$display("Watchdog expired, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	// ##############################
	// Helpers
	// ##############################
	task automatic check(input logic [63:0] got, input logic [63:0] want, input string msg);
		if (got !== want) begin
			$display("Error at %t: %s, got %0h expected %0h", $time, msg, got, want);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		test_cnt++;
		if (err_cnt == err_before) begin
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d mismatches", name, err_cnt - err_before);
		end
	endtask

	task automatic dl_write(input byte_t idx, input dl_addr_t a, input byte_t d);
		@(posedge clk_sys);
		dl_wr    <= 1'b1;
		dl_index <= idx;
		dl_addr  <= a;
		dl_data  <= d;
	endtask

	task automatic dl_end();
		@(posedge clk_sys);
		dl_wr     <= 1'b0;
		dl_active <= 1'b0;
	endtask

	// Random bytes into one region, mirrored in rom_img
	task automatic load_region(input dl_addr_t base, input int n);
		byte_t d;
		for (int i = 0; i < n; i++) begin
			d = byte_t'($urandom);
			rom_img[int'(base + dl_addr_t'(i))] = d;
			dl_write(`DL_INDEX_ROM, base + dl_addr_t'(i), d);
		end
	endtask

	// Page 0 is bank A, page 4 bank B, even byte high
	function automatic word_t prog_expect(input prog_addr_t a);
		dl_addr_t base;
		dl_addr_t ba;
		if (a[18:15] == 4'd0) base = `PROG_A_BASE;
		else if (a[18:15] == 4'd4) base = `PROG_B_BASE;
		else return '0;
		ba = base + {9'd0, a[14:0], 1'b0};
		return {rom_img[int'(ba)], rom_img[int'(ba + 25'd1)]};
	endfunction

	function automatic byte_t snd_expect(input snd_addr_t a);
		if (a[15]) return rom_img[int'(`SND_HI_BASE + {10'd0, a[14:0]})];
		return rom_img[int'(`SND_LO_BASE + {11'd0, a[13:0]})];
	endfunction

	// One read per cycle, data checked one cycle later
	task automatic run_prog_reads();
		int n;
		n = prog_q.size();
		for (int i = 0; i <= n; i++) begin
			@(posedge clk_sys);
			if (i < n) prog_addr <= prog_q[i];
			@(negedge clk_sys);
			if (i > 0) check(64'(prog_data), 64'(prog_expect(prog_q[i-1])), "program read");
		end
		prog_q.delete();
	endtask

	// New event on the toggle bit, result checked after the next edge
	task automatic send_key(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], pressed, code};
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// pos indexes {sys_n, p4, p3, p2, p1}
	task automatic key_check(input logic [8:0] code, input int pos);
		logic [36:0] want;
		want = '1;
		want[pos] = 1'b0;
		send_key(code, 1'b1);
		check(64'({sys_n, p4, p3, p2, p1}), 64'(want), $sformatf("press %h", code));
		send_key(code, 1'b0);
		check(64'({sys_n, p4, p3, p2, p1}), 64'({37{1'b1}}), $sformatf("release %h", code));
	endtask

	// ##############################
	// Tests
	// ##############################
	task automatic test_reset_idle();
		int e;
		e = err_cnt;
		@(negedge clk_sys);
		check(64'(game_rst), 64'(1), "game_rst during reset");
		@(posedge clk_sys);
		rst <= 1'b0;                   // Held for two edges
		@(negedge clk_sys);
		check(64'({sys_n, p4, p3, p2, p1}), 64'({37{1'b1}}), "idle inputs");
		check(64'(slap_type), 64'(104), "slap_type after reset");
		check(dip_sw, 64'(0), "dip_sw after reset");
		check(64'(game_rst), 64'(0), "game_rst idle");
		@(posedge clk_sys);
		dl_active <= 1'b1;
		@(negedge clk_sys);
		check(64'(game_rst), 64'(1), "game_rst in download");
		dl_end();
		@(negedge clk_sys);
		check(64'(game_rst), 64'(0), "game_rst after download");
		report_test("reset and idle", e);
	endtask

	task automatic test_prog_rom();
		int e;
		e = err_cnt;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		load_region(`PROG_A_BASE, n_prog_bytes);
		load_region(`PROG_B_BASE, n_prog_bytes);
		dl_end();
		for (int w = 0; w < n_prog_bytes / 2; w++) begin
			prog_q.push_back({4'd0, 15'(w)});
			prog_q.push_back({4'd4, 15'(w)});
		end
		prog_q.push_back({4'd2, 15'd5}); // Unmapped page
		run_prog_reads();
		report_test("program rom", e);
	endtask

	task automatic test_snd_chr_rom();
		int e;
		snd_addr_t sa [$];
		e = err_cnt;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		load_region(`SND_HI_BASE, n_byte_bytes);
		load_region(`SND_LO_BASE, n_byte_bytes);
		load_region(`CHR_BASE, n_byte_bytes);
		dl_end();
		for (int i = 0; i < n_byte_bytes; i++) begin
			sa.push_back({1'b1, 15'(i)});
			sa.push_back({1'b0, 15'(i)});
		end
		for (int i = 0; i <= sa.size(); i++) begin
			@(posedge clk_sys);
			if (i < sa.size()) begin
				snd_addr <= sa[i];
				chr_addr <= chr_addr_t'(i % n_byte_bytes);
			end
			@(negedge clk_sys);
			if (i > 0) begin
				check(64'(snd_data), 64'(snd_expect(sa[i-1])), "audio read");
				check(64'(chr_data),
					64'(rom_img[int'(`CHR_BASE) + (i - 1) % n_byte_bytes]), "character read");
			end
		end
		report_test("audio and character rom", e);
	endtask

	task automatic test_config();
		int e;
		byte_t d;
		logic [63:0] want_dip;
		e = err_cnt;
		want_dip = '0;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		// Odd bank A address, which a ROM write would hit
		dl_write(`DL_INDEX_SLAP, `PROG_A_BASE + 25'd3, 8'd77);
		for (int k = 7; k >= 0; k--) begin
			d = byte_t'($urandom);
			want_dip[8*k +: 8] = d;
			dl_write(`DL_INDEX_DIP, dl_addr_t'(k), d);
		end
		// Past the eight switch bytes, also odd in bank A
		dl_write(`DL_INDEX_DIP, `PROG_A_BASE + 25'd1, 8'h5A);
		dl_end();
		@(negedge clk_sys);
		check(64'(slap_type), 64'(77), "slap_type load");
		check(dip_sw, want_dip, "dip_sw bytes");
		prog_q.push_back({4'd0, 15'd0});
		prog_q.push_back({4'd0, 15'd1});
		run_prog_reads();
		dl_write(`DL_INDEX_SLAP, 25'd0, `SLAP_DEFAULT);
		dl_end();
		@(negedge clk_sys);
		check(64'(slap_type), 64'(104), "slap_type restore");
		report_test("configuration", e);
	endtask

	task automatic test_gauntlet_map();
		int e;
		logic [8:0] codes [10] = '{9'h075, 9'h172, 9'h06B, 9'h174, 9'h014,
			9'h011, 9'h023, 9'h01C, 9'h02E, 9'h03E};
		int pos [10] = '{7, 6, 5, 4, 1, 0, 13, 9, 35, 32};
		logic [36:0] want;
		e = err_cnt;
		for (int i = 0; i < 10; i++) key_check(codes[i], pos[i]);
		// Joystick alone, no key held
		@(posedge clk_sys);
		joy0 <= 16'h0008;              // Bit 3 to p1 bit 7
		joy1 <= 16'h0010;              // Fire to p2 bit 1
		joy2 <= 16'h0020;              // Magic to p3 bit 0
		joy3 <= 16'h0040;              // Coin 4
		service <= 1'b1;
		@(negedge clk_sys);
		want = '1;
		want[7] = 1'b0;
		want[9] = 1'b0;
		want[16] = 1'b0;
		want[32] = 1'b0;
		want[36] = 1'b0;
		check(64'({sys_n, p4, p3, p2, p1}), 64'(want), "joystick merge");
		@(posedge clk_sys);
		{joy0, joy1, joy2, joy3} <= '0;
		service <= 1'b0;
		report_test("gauntlet mapping", e);
	endtask

	task automatic test_tank_map();
		int e;
		e = err_cnt;
		dl_write(`DL_INDEX_SLAP, 25'd0, `SLAP_TANK);
		dl_end();
		@(negedge clk_sys);
		check(64'(slap_type), 64'(118), "slap_type tank");
		key_check(9'h023, 7);          // p1 bit 7, not p2 bit 5
		key_check(9'h016, 16);         // Start 1
		key_check(9'h036, 34);         // Coin 2
		report_test("tank mapping", e);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(32'hebc9));
		rst <= 1'b1;
		{dl_wr, dl_active, service} <= '0;
		{dl_index, dl_data, dl_addr} <= '0;
		{prog_addr, snd_addr, chr_addr, ps2_key} <= '0;
		{joy0, joy1, joy2, joy3} <= '0;
		test_reset_idle();
		test_prog_rom();
		test_snd_chr_rom();
		test_config();
		test_gauntlet_map();
		test_tank_map();
		$display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) $display("TEST PASSED");
		else $display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
